// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module decode_stage_tb -f src.f

output=$(./obj_dir/Vdecode_stage_tb)
echo "$output"

if echo "$output" | grep -q "TEST PASS"; then
    exit 0
fi
exit 1

// ==== source/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    localparam int decode_width = 4;  // slots per fetch bundle.
    localparam int imm_width = 13;    // wide enough for the B-immediate.
    localparam int xlen = 32;
    localparam int reg_width = 5;
    localparam int csr_id_width = 12;

    // major opcodes, low two bits included.
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_jalr = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op_reg = 7'b0110011;
    localparam logic [6:0] opc_system = 7'b1110011;

    typedef enum logic [3:0] {
        kind_lui = 4'd0,
        kind_auipc = 4'd1,
        kind_jal = 4'd2,
        kind_jalr = 4'd3,
        kind_branch = 4'd4,
        kind_load = 4'd5,
        kind_store = 4'd6,
        kind_op_imm = 4'd7,
        kind_op_reg = 4'd8,
        kind_system = 4'd9,
        kind_unknown = 4'd10
    } op_kind_e;

    typedef enum logic [4:0] {
        int_add = 5'd0,
        int_lui = 5'd1,
        int_slt = 5'd2,   // sltu as well, with uext set.
        int_sub = 5'd3,
        int_xor = 5'd4,
        int_and = 5'd5,
        int_or = 5'd6,
        int_sll = 5'd8,
        int_srl = 5'd9,
        int_sra = 5'd10,
        int_auipc = 5'd12
    } int_op_e;

    typedef enum logic [2:0] {
        br_beq = 3'd0,
        br_bne = 3'd1,
        br_blt = 3'd2,    // bltu too when uext is set.
        br_bge = 3'd3,    // bgeu too when uext is set.
        br_jal = 3'd4,
        br_jalr = 3'd5
    } branch_op_e;

    // bit 3 store, bit 2 unsigned, bit 1 word, bit 0 half.
    typedef enum logic [3:0] {
        mem_lb = 4'b0000,
        mem_lh = 4'b0001,
        mem_lw = 4'b0010,
        mem_lbu = 4'b0100,
        mem_lhu = 4'b0101,
        mem_sb = 4'b1000,
        mem_sh = 4'b1001,
        mem_sw = 4'b1010
    } mem_op_e;

    typedef struct packed {
        op_kind_e kind;
        logic intv;
        logic branchv;
        logic memv;
        logic csrv;
        int_op_e intop;
        branch_op_e branchop;
        mem_op_e memop;
        logic [2:0] csrop;
        logic [csr_id_width-1:0] csrid;
        logic uext;
        logic immv;
        logic [imm_width-1:0] imm;
        logic [reg_width-1:0] rs1;
        logic [reg_width-1:0] rs2;
        logic [reg_width-1:0] rd;
        logic we;
    } decode_info_t;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] inst;
        logic [xlen-1:0] pc;
    } fetch_slot_t;

    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        decode_info_t info;
        logic raw_dep;    // set when an earlier slot of the bundle writes a source.
    } dispatch_slot_t;

endpackage

`default_nettype wire

// ==== source/decode_stage.sv ====
`default_nettype none

module decode_stage (
    input wire logic clk,
    input wire logic reset,
    input wire logic flush,
    input wire logic fetch_valid,
    input wire logic [decode_pkg::decode_width-1:0] fetch_mask,
    input wire logic [decode_pkg::xlen-1:0] fetch_pc,
    input wire logic [decode_pkg::xlen-1:0] fetch_inst [decode_pkg::decode_width],
    output wire decode_pkg::dispatch_slot_t dispatch_slots [decode_pkg::decode_width],
    output wire logic dispatch_valid
);

    wire decode_pkg::fetch_slot_t fetch_slots [decode_pkg::decode_width];
    wire decode_pkg::decode_info_t infos [decode_pkg::decode_width];
    wire decode_pkg::dispatch_slot_t decoded [decode_pkg::decode_width];

    fetch_latch u_fetch_latch (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .fetch_valid(fetch_valid),
        .fetch_mask(fetch_mask),
        .fetch_pc(fetch_pc),
        .fetch_inst(fetch_inst),
        .slots(fetch_slots)
    );

    for (genvar i = 0; i < decode_pkg::decode_width; i++) begin : g_dec
        decode_unit u_decode_unit (
            .inst(fetch_slots[i].inst),
            .info(infos[i])
        );

        assign decoded[i] = decode_pkg::dispatch_slot_t'{   // raw_dep is filled in later.
            valid: fetch_slots[i].valid,
            pc: fetch_slots[i].pc,
            info: infos[i],
            raw_dep: 1'b0
        };
    end

    dispatch_reg u_dispatch_reg (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .slots_in(decoded),
        .slots_out(dispatch_slots),
        .dispatch_valid(dispatch_valid)
    );

endmodule

`default_nettype wire

// ==== source/decode_unit.sv ====
`default_nettype none

module decode_unit (
    input wire logic [decode_pkg::xlen-1:0] inst,
    output decode_pkg::decode_info_t info
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic alt;
    decode_pkg::op_kind_e kind;
    logic is_shift;
    logic is_csr;
    logic use_rs1;
    logic use_rs2;
    logic use_rd;
    logic [decode_pkg::reg_width-1:0] rd;
    logic [decode_pkg::imm_width-1:0] imm_b;
    logic [decode_pkg::imm_width-1:0] imm_s;
    logic [decode_pkg::imm_width-1:0] imm_i;
    logic [decode_pkg::imm_width-1:0] imm_shamt;
    logic [decode_pkg::imm_width-1:0] imm_csr;

    // shared by op_imm and op_reg, which differ only in sub.
    function automatic decode_pkg::int_op_e alu_op(input logic [2:0] f3, input logic alt_sub,
                                                   input logic alt_shift);
        decode_pkg::int_op_e op;
        case (f3)
            3'b000: op = alt_sub ? decode_pkg::int_sub : decode_pkg::int_add;
            3'b001: op = decode_pkg::int_sll;
            3'b010, 3'b011: op = decode_pkg::int_slt;
            3'b100: op = decode_pkg::int_xor;
            3'b101: op = alt_shift ? decode_pkg::int_sra : decode_pkg::int_srl;
            3'b110: op = decode_pkg::int_or;
            default: op = decode_pkg::int_and;
        endcase
        return op;
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt = inst[30];

    // compressed words never match, since each opcode ends in 2'b11.
    always_comb begin
        case (opcode)
            decode_pkg::opc_lui: kind = decode_pkg::kind_lui;
            decode_pkg::opc_auipc: kind = decode_pkg::kind_auipc;
            decode_pkg::opc_jal: kind = decode_pkg::kind_jal;
            decode_pkg::opc_jalr: kind = decode_pkg::kind_jalr;
            decode_pkg::opc_branch: kind = decode_pkg::kind_branch;
            decode_pkg::opc_load: kind = decode_pkg::kind_load;
            decode_pkg::opc_store: kind = decode_pkg::kind_store;
            decode_pkg::opc_op_imm: kind = decode_pkg::kind_op_imm;
            decode_pkg::opc_op_reg: kind = decode_pkg::kind_op_reg;
            decode_pkg::opc_system: kind = decode_pkg::kind_system;
            default: kind = decode_pkg::kind_unknown;
        endcase
    end

    assign is_shift = (kind == decode_pkg::kind_op_imm) && (funct3[1:0] == 2'b01);
    assign is_csr = (kind == decode_pkg::kind_system) && (funct3[1:0] != 2'b00);

    assign use_rs1 = kind inside {decode_pkg::kind_jalr, decode_pkg::kind_branch,
                                  decode_pkg::kind_load, decode_pkg::kind_store,
                                  decode_pkg::kind_op_imm, decode_pkg::kind_op_reg,
                                  decode_pkg::kind_system};
    assign use_rs2 = kind inside {decode_pkg::kind_branch, decode_pkg::kind_store,
                                  decode_pkg::kind_op_reg} || (is_csr && !funct3[2]);
    assign use_rd = kind inside {decode_pkg::kind_lui, decode_pkg::kind_auipc,
                                 decode_pkg::kind_jal, decode_pkg::kind_jalr,
                                 decode_pkg::kind_load, decode_pkg::kind_op_imm,
                                 decode_pkg::kind_op_reg, decode_pkg::kind_system};

    assign rd = use_rd ? inst[11:7] : '0;

    assign imm_b = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_s = {inst[31], inst[31:25], inst[11:7]};   // sign extended to imm_width.
    assign imm_i = {inst[31], inst[31:20]};
    assign imm_shamt = {{(decode_pkg::imm_width - 5){1'b0}}, inst[24:20]};
    assign imm_csr = {{(decode_pkg::imm_width - 5){1'b0}}, inst[19:15]};  // zimm of csr forms.

    always_comb begin
        info = '0;
        info.kind = kind;
        info.rs1 = use_rs1 ? inst[19:15] : '0;
        info.rs2 = use_rs2 ? inst[24:20] : '0;
        info.rd = rd;
        info.we = (rd != '0);

        if (kind == decode_pkg::kind_branch) begin
            info.imm = imm_b;
        end else if (is_shift) begin
            info.imm = imm_shamt;
        end else if (is_csr) begin
            info.imm = imm_csr;
        end else if (kind == decode_pkg::kind_store) begin
            info.imm = imm_s;
        end else if (kind == decode_pkg::kind_jal) begin
            info.imm = '0;
        end else begin
            info.imm = imm_i;
        end

        case (kind)
            decode_pkg::kind_lui: begin
                info.intv = 1'b1;
                info.intop = decode_pkg::int_lui;
            end
            decode_pkg::kind_auipc: begin
                info.intv = 1'b1;
                info.intop = decode_pkg::int_auipc;
            end
            decode_pkg::kind_jal: begin
                info.branchv = 1'b1;
                info.branchop = decode_pkg::br_jal;
            end
            decode_pkg::kind_jalr: begin
                info.branchv = 1'b1;
                info.branchop = decode_pkg::br_jalr;
            end
            decode_pkg::kind_branch: begin
                info.branchv = 1'b1;
                info.uext = funct3[2] & funct3[1];   // bltu and bgeu.
                case (funct3)
                    3'b001: info.branchop = decode_pkg::br_bne;
                    3'b100, 3'b110: info.branchop = decode_pkg::br_blt;
                    3'b101, 3'b111: info.branchop = decode_pkg::br_bge;
                    default: info.branchop = decode_pkg::br_beq;
                endcase
            end
            decode_pkg::kind_load: begin
                info.memv = 1'b1;
                info.uext = funct3[2];
                case (funct3)
                    3'b001: info.memop = decode_pkg::mem_lh;
                    3'b010: info.memop = decode_pkg::mem_lw;
                    3'b100: info.memop = decode_pkg::mem_lbu;
                    3'b101: info.memop = decode_pkg::mem_lhu;
                    default: info.memop = decode_pkg::mem_lb;
                endcase
            end
            decode_pkg::kind_store: begin
                info.memv = 1'b1;
                case (funct3)
                    3'b001: info.memop = decode_pkg::mem_sh;
                    3'b010: info.memop = decode_pkg::mem_sw;
                    default: info.memop = decode_pkg::mem_sb;
                endcase
            end
            decode_pkg::kind_op_imm: begin
                info.intv = 1'b1;
                info.immv = 1'b1;
                info.uext = (funct3 == 3'b011);
                info.intop = alu_op(funct3, 1'b0, alt);
            end
            decode_pkg::kind_op_reg: begin
                info.intv = 1'b1;
                info.uext = (funct3 == 3'b011);
                info.intop = alu_op(funct3, alt, alt);
            end
            decode_pkg::kind_system: begin
                info.csrv = is_csr;   // ecall and ebreak carry no csr access.
                info.csrop = funct3;
                info.csrid = inst[31:20];
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/dispatch_reg.sv ====
`default_nettype none

module dispatch_reg (
    input wire logic clk,
    input wire logic reset,
    input wire logic flush,
    input wire decode_pkg::dispatch_slot_t slots_in [decode_pkg::decode_width],
    output decode_pkg::dispatch_slot_t slots_out [decode_pkg::decode_width],
    output logic dispatch_valid
);

    logic [decode_pkg::decode_width-1:0] raw_dep;
    logic [decode_pkg::decode_width-1:0] valid_q;
    logic [decode_pkg::decode_width-1:0] raw_dep_q;
    logic [decode_pkg::xlen-1:0] pc_q [decode_pkg::decode_width];
    decode_pkg::decode_info_t info_q [decode_pkg::decode_width];

    // we implies a nonzero rd, so a match never fires on x0.
    always_comb begin
        for (int i = 0; i < decode_pkg::decode_width; i++) begin
            raw_dep[i] = 1'b0;
            for (int j = 0; j < i; j++) begin
                if (slots_in[j].valid && slots_in[j].info.we &&
                    (slots_in[j].info.rd == slots_in[i].info.rs1 ||
                     slots_in[j].info.rd == slots_in[i].info.rs2)) begin
                    raw_dep[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < decode_pkg::decode_width; i++) begin
                valid_q[i] <= slots_in[i].valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        raw_dep_q <= raw_dep;
        for (int i = 0; i < decode_pkg::decode_width; i++) begin
            pc_q[i] <= slots_in[i].pc;
            info_q[i] <= slots_in[i].info;
        end
    end

    always_comb begin
        for (int i = 0; i < decode_pkg::decode_width; i++) begin
            slots_out[i].valid = valid_q[i];
            slots_out[i].pc = pc_q[i];
            slots_out[i].info = info_q[i];
            slots_out[i].raw_dep = raw_dep_q[i];
        end
    end

    assign dispatch_valid = |valid_q;

endmodule

`default_nettype wire

// ==== source/fetch_latch.sv ====
`default_nettype none

module fetch_latch (
    input wire logic clk,
    input wire logic reset,
    input wire logic flush,
    input wire logic fetch_valid,
    input wire logic [decode_pkg::decode_width-1:0] fetch_mask,
    input wire logic [decode_pkg::xlen-1:0] fetch_pc,
    input wire logic [decode_pkg::xlen-1:0] fetch_inst [decode_pkg::decode_width],
    output decode_pkg::fetch_slot_t slots [decode_pkg::decode_width]
);

    logic [decode_pkg::decode_width-1:0] valid_q;
    logic [decode_pkg::xlen-1:0] inst_q [decode_pkg::decode_width];
    logic [decode_pkg::xlen-1:0] pc_q [decode_pkg::decode_width];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_q <= '0;
        end else begin
            valid_q <= fetch_mask & {decode_pkg::decode_width{fetch_valid}};
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && !flush && !reset) begin
            for (int i = 0; i < decode_pkg::decode_width; i++) begin
                inst_q[i] <= fetch_inst[i];
                pc_q[i] <= fetch_pc + decode_pkg::xlen'(4 * i);  // one word per slot.
            end
        end
    end

    always_comb begin
        for (int i = 0; i < decode_pkg::decode_width; i++) begin
            slots[i].valid = valid_q[i];
            slots[i].inst = inst_q[i];
            slots[i].pc = pc_q[i];
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verif
source/decode_pkg.sv
source/fetch_latch.sv
source/decode_unit.sv
source/dispatch_reg.sv
source/decode_stage.sv
verif/decode_stage_tb.sv

// ==== verif/decode_ref.svh ====
`ifndef decode_ref_svh
`define decode_ref_svh

// expected decode record of one word, built from the RV32I and Zicsr encodings.
function automatic decode_pkg::decode_info_t ref_decode(input logic [31:0] w);
    decode_pkg::decode_info_t d;
    logic [2:0] f3;
    logic csr;
    d = '0;
    f3 = w[14:12];
    case (w[6:0])
        7'b0110111: d.kind = decode_pkg::kind_lui;
        7'b0010111: d.kind = decode_pkg::kind_auipc;
        7'b1101111: d.kind = decode_pkg::kind_jal;
        7'b1100111: d.kind = decode_pkg::kind_jalr;
        7'b1100011: d.kind = decode_pkg::kind_branch;
        7'b0000011: d.kind = decode_pkg::kind_load;
        7'b0100011: d.kind = decode_pkg::kind_store;
        7'b0010011: d.kind = decode_pkg::kind_op_imm;
        7'b0110011: d.kind = decode_pkg::kind_op_reg;
        7'b1110011: d.kind = decode_pkg::kind_system;
        default: d.kind = decode_pkg::kind_unknown;
    endcase
    csr = (d.kind == decode_pkg::kind_system) && (f3 != 3'b000) && (f3 != 3'b100);

    if (!(d.kind inside {decode_pkg::kind_lui, decode_pkg::kind_auipc, decode_pkg::kind_jal,
                         decode_pkg::kind_unknown})) begin
        d.rs1 = w[19:15];
    end
    if ((d.kind inside {decode_pkg::kind_branch, decode_pkg::kind_store,
                        decode_pkg::kind_op_reg}) || (csr && !f3[2])) begin
        d.rs2 = w[24:20];
    end
    if (!(d.kind inside {decode_pkg::kind_branch, decode_pkg::kind_store,
                         decode_pkg::kind_unknown})) begin
        d.rd = w[11:7];
    end
    d.we = (d.rd != 5'd0);

    if (d.kind == decode_pkg::kind_branch) d.imm = {w[31], w[7], w[30:25], w[11:8], 1'b0};
    else if (d.kind == decode_pkg::kind_op_imm && f3[1:0] == 2'b01) d.imm = {8'b0, w[24:20]};
    else if (csr) d.imm = {8'b0, w[19:15]};
    else if (d.kind == decode_pkg::kind_store) d.imm = {w[31], w[31:25], w[11:7]};
    else if (d.kind == decode_pkg::kind_jal) d.imm = '0;
    else d.imm = {w[31], w[31:20]};

    d.intv = d.kind inside {decode_pkg::kind_lui, decode_pkg::kind_auipc,
                            decode_pkg::kind_op_imm, decode_pkg::kind_op_reg};
    d.branchv = d.kind inside {decode_pkg::kind_jal, decode_pkg::kind_jalr,
                               decode_pkg::kind_branch};
    d.memv = d.kind inside {decode_pkg::kind_load, decode_pkg::kind_store};
    d.csrv = csr;
    d.immv = (d.kind == decode_pkg::kind_op_imm);
    if (d.kind == decode_pkg::kind_lui) d.intop = decode_pkg::int_lui;
    if (d.kind == decode_pkg::kind_auipc) d.intop = decode_pkg::int_auipc;
    if (d.kind == decode_pkg::kind_jal) d.branchop = decode_pkg::br_jal;
    if (d.kind == decode_pkg::kind_jalr) d.branchop = decode_pkg::br_jalr;

    case (d.kind)
        decode_pkg::kind_branch: begin
            d.uext = (f3 == 3'b110) || (f3 == 3'b111);
            case (f3)
                3'b001: d.branchop = decode_pkg::br_bne;
                3'b100, 3'b110: d.branchop = decode_pkg::br_blt;
                3'b101, 3'b111: d.branchop = decode_pkg::br_bge;
                default: d.branchop = decode_pkg::br_beq;
            endcase
        end
        decode_pkg::kind_load: begin
            d.uext = f3[2];
            case (f3)
                3'b001: d.memop = decode_pkg::mem_lh;
                3'b010: d.memop = decode_pkg::mem_lw;
                3'b100: d.memop = decode_pkg::mem_lbu;
                3'b101: d.memop = decode_pkg::mem_lhu;
                default: d.memop = decode_pkg::mem_lb;
            endcase
        end
        decode_pkg::kind_store: begin
            case (f3)
                3'b001: d.memop = decode_pkg::mem_sh;
                3'b010: d.memop = decode_pkg::mem_sw;
                default: d.memop = decode_pkg::mem_sb;
            endcase
        end
        decode_pkg::kind_op_imm, decode_pkg::kind_op_reg: begin
            d.uext = (f3 == 3'b011);   // sltu and sltiu.
            case (f3)
                3'b000: begin
                    if (d.kind == decode_pkg::kind_op_reg && w[30]) d.intop = decode_pkg::int_sub;
                    else d.intop = decode_pkg::int_add;
                end
                3'b001: d.intop = decode_pkg::int_sll;
                3'b010, 3'b011: d.intop = decode_pkg::int_slt;
                3'b100: d.intop = decode_pkg::int_xor;
                3'b101: d.intop = w[30] ? decode_pkg::int_sra : decode_pkg::int_srl;
                3'b110: d.intop = decode_pkg::int_or;
                default: d.intop = decode_pkg::int_and;
            endcase
        end
        decode_pkg::kind_system: begin
            d.csrop = f3;
            d.csrid = w[31:20];
        end
        default: begin
        end
    endcase
    return d;
endfunction

// an earlier valid slot that writes one of this slot's nonzero sources.
function automatic logic [decode_pkg::decode_width-1:0] ref_deps(
        input logic [decode_pkg::decode_width-1:0][31:0] insts,
        input logic [decode_pkg::decode_width-1:0] valid);
    decode_pkg::decode_info_t older;
    decode_pkg::decode_info_t younger;
    logic [decode_pkg::decode_width-1:0] deps;
    deps = '0;
    for (int i = 1; i < decode_pkg::decode_width; i++) begin
        younger = ref_decode(insts[i]);
        for (int j = 0; j < i; j++) begin
            older = ref_decode(insts[j]);
            if (valid[j] && older.we &&
                ((younger.rs1 != 5'd0 && younger.rs1 == older.rd) ||
                 (younger.rs2 != 5'd0 && younger.rs2 == older.rd))) begin
                deps[i] = 1'b1;
            end
        end
    end
    return deps;
endfunction

`endif

// ==== verif/decode_stage_tb.sv ====
`default_nettype none

module decode_stage_tb;

    logic clk = 1'b0;
    logic reset;
    logic flush;
    logic fetch_valid;
    logic [decode_pkg::decode_width-1:0] fetch_mask;
    logic [31:0] fetch_pc;
    logic [31:0] fetch_inst [decode_pkg::decode_width];
    wire decode_pkg::dispatch_slot_t dispatch_slots [decode_pkg::decode_width];
    wire logic dispatch_valid;

    integer seed;
    logic [decode_pkg::decode_width-1:0] lat_valid = '0;   // image of the fetch latch.
    logic [31:0] lat_base = '0;
    logic [decode_pkg::decode_width-1:0][31:0] lat_inst = '0;
    logic [decode_pkg::decode_width-1:0] out_valid = '0;   // image of the dispatch register.
    logic [decode_pkg::decode_width-1:0] out_dep = '0;
    logic [31:0] out_base = '0;
    logic [decode_pkg::decode_width-1:0][31:0] out_inst = '0;
    logic [decode_pkg::decode_width-1:0][31:0] bundle;

    `include "decode_ref.svh"

    decode_stage dut (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .fetch_valid(fetch_valid),
        .fetch_mask(fetch_mask),
        .fetch_pc(fetch_pc),
        .fetch_inst(fetch_inst),
        .dispatch_slots(dispatch_slots),
        .dispatch_valid(dispatch_valid)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_info(input int slot, input decode_pkg::decode_info_t got,
                              input decode_pkg::decode_info_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: dispatch_slots[%0d].info got %h expected %h",
                                $time, slot, got, exp));
        end
    endtask

    task automatic check_slot_valid(input logic [decode_pkg::decode_width-1:0] got,
                                    input logic got_any,
                                    input logic [decode_pkg::decode_width-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: dispatch_slots valid got %b expected %b",
                                $time, got, exp));
        end
        if (got_any !== (|exp)) begin
            abort_run($sformatf("Fail at %0t: dispatch_valid got %b expected %b",
                                $time, got_any, |exp));
        end
    endtask

    task automatic check_dep(input logic [decode_pkg::decode_width-1:0] got,
                             input logic [decode_pkg::decode_width-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: dispatch_slots raw_dep got %b expected %b",
                                $time, got, exp));
        end
    endtask

    task automatic check_pc(input int slot, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: dispatch_slots[%0d].pc got %h expected %h",
                                $time, slot, got, exp));
        end
    endtask

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    // mostly legal encodings, the rest fully random words.
    function automatic logic [31:0] gen_inst();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] hi;
        r = $random(seed);
        s = $random(seed);
        rd = {2'b00, s[6:4]};   // few registers, so hazards show up often.
        rs1 = {2'b00, s[9:7]};
        rs2 = {2'b00, s[12:10]};
        f3 = s[15:13];
        case (s[3:0])
            4'd0: return {r[31:12], rd, 7'b0110111};
            4'd1: return {r[31:12], rd, 7'b0010111};
            4'd2: return {r[31:12], rd, 7'b1101111};
            4'd3: return {r[31:20], rs1, 3'b000, rd, 7'b1100111};
            4'd4: begin
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;
                return {r[31:25], rs2, rs1, f3, r[11:7], 7'b1100011};
            end
            4'd5: begin
                if (f3 == 3'b011 || f3[2:1] == 2'b11) f3 = 3'b010;
                return {r[31:20], rs1, f3, rd, 7'b0000011};
            end
            4'd6: begin
                f3[2] = 1'b0;
                if (f3[1:0] == 2'b11) f3[0] = 1'b0;
                return {r[31:25], rs2, rs1, f3, r[11:7], 7'b0100011};
            end
            4'd7: begin
                hi = r[31:25];
                if (f3 == 3'b001) hi = 7'b0;
                if (f3 == 3'b101) hi = {1'b0, r[30], 5'b0};
                return {hi, r[24:20], rs1, f3, rd, 7'b0010011};
            end
            4'd8, 4'd9: begin
                hi = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, r[30], 5'b0} : 7'b0;
                return {hi, rs2, rs1, f3, rd, 7'b0110011};
            end
            4'd10: begin
                if (f3 == 3'b100) f3 = 3'b001;
                return {r[31:20], rs1, f3, rd, 7'b1110011};
            end
            default: return r;
        endcase
    endfunction

    function automatic logic [decode_pkg::decode_width-1:0][31:0] random_bundle();
        logic [decode_pkg::decode_width-1:0][31:0] b;
        for (int i = 0; i < decode_pkg::decode_width; i++) begin
            b[i] = gen_inst();
        end
        return b;
    endfunction

    task automatic drive_bundle(input logic valid, input logic [decode_pkg::decode_width-1:0] mask,
                                input logic [31:0] base,
                                input logic [decode_pkg::decode_width-1:0][31:0] insts,
                                input logic fl);
        @(negedge clk);
        fetch_valid = valid;
        fetch_mask = mask;
        fetch_pc = base;
        flush = fl;
        for (int i = 0; i < decode_pkg::decode_width; i++) begin
            fetch_inst[i] = insts[i];
        end
    endtask

    // expectation pipeline and compare, one step per rising edge.
    initial begin
        logic [decode_pkg::decode_width-1:0] got_valid;
        logic [decode_pkg::decode_width-1:0] got_dep;
        forever begin
            @(posedge clk);
            if (reset || flush) begin
                out_valid = '0;
                lat_valid = '0;
            end else begin
                out_valid = lat_valid;
                out_base = lat_base;
                out_inst = lat_inst;
                out_dep = ref_deps(lat_inst, lat_valid);
                lat_valid = fetch_mask & {decode_pkg::decode_width{fetch_valid}};
            end
            if (fetch_valid && !flush && !reset) begin
                lat_base = fetch_pc;
                for (int i = 0; i < decode_pkg::decode_width; i++) begin
                    lat_inst[i] = fetch_inst[i];
                end
            end
            #1;
            for (int i = 0; i < decode_pkg::decode_width; i++) begin
                got_valid[i] = dispatch_slots[i].valid;
                got_dep[i] = dispatch_slots[i].raw_dep;
            end
            check_slot_valid(got_valid, dispatch_valid, out_valid);
            check_dep(got_dep & out_valid, out_dep & out_valid);
            for (int i = 0; i < decode_pkg::decode_width; i++) begin
                if (out_valid[i]) begin
                    check_pc(i, dispatch_slots[i].pc, out_base + 32'(4 * i));
                    check_info(i, dispatch_slots[i].info, ref_decode(out_inst[i]));
                end
            end
        end
    end

    initial begin
        int n;
        logic [31:0] r;
        logic [31:0] base;
        seed = 32'h3eda;
        reset = 1'b1;
        flush = 1'b0;
        fetch_valid = 1'b0;
        fetch_mask = '0;
        fetch_pc = '0;
        for (int i = 0; i < decode_pkg::decode_width; i++) begin
            fetch_inst[i] = '0;
        end
        repeat (3) @(negedge clk);
        reset = 1'b0;
        n = 0;
        while (dispatch_valid !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > 10) abort_run("dispatch_valid did not clear after reset");
        end
        drive_bundle(1'b0, 4'b0000, 32'h0, '0, 1'b0);
        drive_bundle(1'b0, 4'b0000, 32'h0, '0, 1'b0);

        bundle[0] = enc_addi(5'd0, 5'd1, 12'd1);   // writes x0, read by the next slot.
        bundle[1] = enc_add(5'd2, 5'd0, 5'd0);
        bundle[2] = enc_addi(5'd3, 5'd0, 12'd7);
        bundle[3] = enc_add(5'd4, 5'd3, 5'd0);
        drive_bundle(1'b1, 4'b1111, 32'h0000_1000, bundle, 1'b0);
        bundle[0] = enc_addi(5'd5, 5'd0, 12'd1);   // masked off below.
        bundle[1] = enc_add(5'd6, 5'd5, 5'd5);
        bundle[2] = enc_add(5'd7, 5'd6, 5'd0);
        bundle[3] = enc_addi(5'd0, 5'd0, 12'd0);
        drive_bundle(1'b1, 4'b1110, 32'h0000_1100, bundle, 1'b0);
        bundle[0] = enc_addi(5'd1, 5'd0, 12'd1);
        bundle[1] = enc_addi(5'd2, 5'd1, 12'd1);
        bundle[2] = enc_addi(5'd3, 5'd2, 12'd1);
        bundle[3] = enc_add(5'd4, 5'd3, 5'd1);
        drive_bundle(1'b1, 4'b1111, 32'h0000_1200, bundle, 1'b0);

        // two bundles in flight when the flush arrives.
        drive_bundle(1'b1, 4'b1111, 32'h0000_2000, random_bundle(), 1'b0);
        drive_bundle(1'b1, 4'b1011, 32'h0000_2010, random_bundle(), 1'b0);
        drive_bundle(1'b1, 4'b1111, 32'h0000_2020, random_bundle(), 1'b1);
        drive_bundle(1'b1, 4'b1111, 32'h0000_3000, random_bundle(), 1'b0);

        for (int k = 0; k < 300; k++) begin
            r = $random(seed);
            base = $random(seed);
            drive_bundle(r[3:0] != 4'h0, r[7:4], {base[31:2], 2'b00}, random_bundle(),
                         r[13:8] == 6'h0);
        end

        drive_bundle(1'b0, 4'b0000, 32'h0, '0, 1'b0);
        n = 0;
        while (dispatch_valid !== 1'b0 || lat_valid != '0 || out_valid != '0) begin
            @(negedge clk);
            n++;
            if (n > 10) abort_run("the pipeline did not drain after the last bundle");
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
